// ==== rv32_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_decode import rv32_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   inst_valid,
    input  wire rv32_inst_u             inst,
    input  wire logic [`RV32_XLEN-1:0]  inst_pc,
    input  wire logic [`RV32_XLEN-1:0]  rs1_val,
    input  wire logic [`RV32_XLEN-1:0]  rs2_val,
    input  wire wb_t                    exe_fwd,
    input  wire wb_t                    res_fwd,
    output logic      [`RV32_REG_W-1:0] rs1_idx,
    output logic      [`RV32_REG_W-1:0] rs2_idx,
    output dec_stage_t                  dec
);

    dec_stage_t dec_d;
    logic       has_rd;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       legal;

    // alt picks sub / sra
    function automatic alu_op_e alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // youngest producer wins
    function automatic logic [`RV32_XLEN-1:0] fwd_pick(
        input logic [`RV32_REG_W-1:0] idx,
        input logic [`RV32_XLEN-1:0]  rf_val,
        input wb_t                    near,
        input wb_t                    far
    );
        if (near.valid && near.rd == idx) return near.data;
        if (far.valid && far.rd == idx) return far.data;
        return rf_val;
    endfunction

    assign rs1_idx = inst.r_fmt.rs1;    // same bits in every format
    assign rs2_idx = inst.r_fmt.rs2;

    always_comb begin
        dec_d        = '0;
        dec_d.valid  = inst_valid;
        dec_d.pc     = inst_pc;
        dec_d.rd     = inst.r_fmt.rd;
        dec_d.funct3 = inst.r_fmt.funct3;
        dec_d.alu_op = ALU_ADD;
        dec_d.wb_sel = WB_ALU;
        has_rd       = 1'b0;
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        legal        = 1'b1;
        case (inst.r_fmt.opcode)
            OP_LUI: begin
                dec_d.imm      = {inst.u_fmt.imm, 12'b0};
                dec_d.alu_op   = ALU_PASS_B;
                dec_d.op_b_imm = 1'b1;
                has_rd         = 1'b1;
            end
            OP_AUIPC: begin
                dec_d.imm      = {inst.u_fmt.imm, 12'b0};
                dec_d.op_a_pc  = 1'b1;
                dec_d.op_b_imm = 1'b1;
                has_rd         = 1'b1;
            end
            OP_JAL: begin
                dec_d.imm      = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                                  inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
                dec_d.op_a_pc  = 1'b1;
                dec_d.op_b_imm = 1'b1;
                dec_d.is_jal   = 1'b1;
                dec_d.wb_sel   = WB_LINK;
                has_rd         = 1'b1;
            end
            OP_JALR: begin
                dec_d.imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec_d.op_b_imm = 1'b1;
                dec_d.is_jalr  = 1'b1;
                dec_d.wb_sel   = WB_LINK;
                has_rd         = 1'b1;
                uses_rs1       = 1'b1;
            end
            OP_BRANCH: begin
                dec_d.imm       = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                                   inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
                dec_d.op_a_pc   = 1'b1;     // alu makes the target
                dec_d.op_b_imm  = 1'b1;
                dec_d.is_branch = 1'b1;
                uses_rs1        = 1'b1;
                uses_rs2        = 1'b1;
            end
            OP_LOAD: begin
                dec_d.imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec_d.op_b_imm = 1'b1;
                dec_d.is_load  = 1'b1;
                dec_d.wb_sel   = WB_LOAD;
                has_rd         = 1'b1;
                uses_rs1       = 1'b1;
            end
            OP_STORE: begin
                dec_d.imm      = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi,
                                  inst.s_fmt.imm_lo};
                dec_d.op_b_imm = 1'b1;
                dec_d.is_store = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            OP_IMM: begin
                dec_d.imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec_d.op_b_imm = 1'b1;
                // imm[10] is only an opcode bit for srai
                dec_d.alu_op   = alu_of(inst.i_fmt.funct3,
                                        inst.i_fmt.funct3 == 3'b101 && inst.r_fmt.funct7[5]);
                has_rd         = 1'b1;
                uses_rs1       = 1'b1;
            end
            OP_REG: begin
                dec_d.alu_op = alu_of(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
                has_rd       = 1'b1;
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        dec_d.reg_write = has_rd && inst.r_fmt.rd != '0;   // x0 writes dropped here
        dec_d.rs1_val   = fwd_pick(rs1_idx, rs1_val, exe_fwd, res_fwd);
        dec_d.rs2_val   = fwd_pick(rs2_idx, rs2_val, exe_fwd, res_fwd);
    end

    always_ff @(posedge clk) begin
        dec <= dec_d;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

    // load data only reaches the result stage, one slot gap is required
    a_load_use_gap: assert property (@(posedge clk) disable iff (!rst_n)
        dec.valid && dec.is_load && dec.reg_write && inst_valid |->
            !((uses_rs1 && rs1_idx == dec.rd) || (uses_rs2 && rs2_idx == dec.rd)));

    a_legal_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> legal);

endmodule

`default_nettype wire

// ==== rv32_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_execute import rv32_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire dec_stage_t            dec,
    output wb_t                        exe_fwd,
    output exe_stage_t                 exe,
    output logic                       data_read,
    output logic                       data_write,
    output logic      [`RV32_XLEN-1:0] data_addr,
    output logic      [`RV32_XLEN-1:0] data_wdata,
    output logic      [3:0]            data_mbe
);

    logic [`RV32_XLEN-1:0] op_a;
    logic [`RV32_XLEN-1:0] op_b;
    logic [`RV32_XLEN-1:0] alu_out;
    logic [`RV32_XLEN-1:0] link;
    logic [`RV32_XLEN-1:0] st_data;
    logic [`RV32_XLEN-1:0] st_data_q;
    logic [3:0]            st_mbe_q;
    logic [1:0]            byte_off;
    logic                  cond;
    exe_stage_t            exe_d;

    // offset is pre-aligned, so a plain shift lands on the right lanes
    function automatic logic [3:0] mbe_of(input logic [1:0] size, input logic [1:0] off);
        case (size)
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    assign op_a = dec.op_a_pc ? dec.pc : dec.rs1_val;
    assign op_b = dec.op_b_imm ? dec.imm : dec.rs2_val;
    assign link = dec.pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // beq/bne, blt/bge, bltu/bgeu; funct3[0] inverts
    always_comb begin
        case (dec.funct3[2:1])
            2'b10:   cond = $signed(dec.rs1_val) < $signed(dec.rs2_val);
            2'b11:   cond = dec.rs1_val < dec.rs2_val;
            default: cond = dec.rs1_val == dec.rs2_val;
        endcase
    end

    // halfword drops bit 0, word drops both
    assign byte_off = dec.funct3[1] ? 2'b00 :
                      dec.funct3[0] ? {alu_out[1], 1'b0} : alu_out[1:0];

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   st_data = {4{dec.rs2_val[7:0]}};
            2'b01:   st_data = {2{dec.rs2_val[15:0]}};
            default: st_data = dec.rs2_val;
        endcase
    end

    always_comb begin
        exe_d.valid       = dec.valid;
        exe_d.rd          = dec.rd;
        exe_d.reg_write   = dec.valid && dec.reg_write;
        exe_d.alu_res     = alu_out;
        exe_d.link        = link;
        exe_d.wb_sel      = dec.wb_sel;
        exe_d.funct3      = dec.funct3;
        exe_d.byte_off    = byte_off;
        exe_d.redirect    = dec.valid && (dec.is_jal || dec.is_jalr ||
                                          (dec.is_branch && (cond ^ dec.funct3[0])));
        exe_d.redirect_pc = dec.is_jalr ? {alu_out[31:1], 1'b0} : alu_out;
    end

    // loads are left to the result stage
    assign exe_fwd.valid = dec.valid && dec.reg_write && !dec.is_load;
    assign exe_fwd.rd    = dec.rd;
    assign exe_fwd.data  = (dec.wb_sel == WB_LINK) ? link : alu_out;

    always_ff @(posedge clk) begin
        exe       <= exe_d;
        st_data_q <= st_data;
        if (!rst_n) begin
            exe.valid     <= 1'b0;
            exe.reg_write <= 1'b0;
            exe.redirect  <= 1'b0;
            st_mbe_q      <= '0;
        end else begin
            st_mbe_q <= (dec.valid && dec.is_store) ? mbe_of(dec.funct3[1:0], byte_off) : '0;
        end
    end

    // request lives only in the cycle after decode
    assign data_read  = exe.valid && exe.wb_sel == WB_LOAD;
    assign data_write = |st_mbe_q;
    assign data_addr  = {exe.alu_res[`RV32_XLEN-1:2], 2'b00};
    assign data_wdata = st_data_q;
    assign data_mbe   = data_read ? mbe_of(exe.funct3[1:0], exe.byte_off) : st_mbe_q;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write));

endmodule

`default_nettype wire

// ==== rv32_int_pipe.f ====
+incdir+.
rv32_pkg.sv
rv32_regfile.sv
rv32_decode.sv
rv32_execute.sv
rv32_result.sv
rv32_int_pipe.sv
tb_rv32_int_pipe.sv

// ==== rv32_int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_int_pipe import rv32_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   inst_valid,
    input  wire rv32_inst_u             inst,
    input  wire logic [`RV32_XLEN-1:0]  inst_pc,
    input  wire logic [`RV32_XLEN-1:0]  data_rdata,
    output logic                        data_read,
    output logic                        data_write,
    output logic      [`RV32_XLEN-1:0]  data_addr,
    output logic      [`RV32_XLEN-1:0]  data_wdata,
    output logic      [3:0]             data_mbe,
    output logic                        wb_valid,
    output logic      [`RV32_REG_W-1:0] wb_rd,
    output logic      [`RV32_XLEN-1:0]  wb_data,
    output logic                        redirect_valid,
    output logic      [`RV32_XLEN-1:0]  redirect_pc
);

    logic [`RV32_REG_W-1:0] rs1_idx;
    logic [`RV32_REG_W-1:0] rs2_idx;
    logic [`RV32_XLEN-1:0]  rs1_val;
    logic [`RV32_XLEN-1:0]  rs2_val;
    dec_stage_t             dec;
    exe_stage_t             exe;
    wb_t                    exe_fwd;
    wb_t                    res_fwd;
    wb_t                    wb;

    rv32_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .wr      (res_fwd),     // same edge that shows wb at the ports
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv32_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .exe_fwd    (exe_fwd),
        .res_fwd    (res_fwd),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .dec        (dec)
    );

    rv32_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec),
        .exe_fwd    (exe_fwd),
        .exe        (exe),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe)
    );

    rv32_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .exe            (exe),
        .data_rdata     (data_rdata),
        .res_fwd        (res_fwd),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

// ==== rv32_macros.svh ====
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// data path and address width
`define RV32_XLEN 32

// architectural registers including x0
`define RV32_REG_COUNT 32

// register index width
`define RV32_REG_W 5

`endif

// ==== rv32_pkg.sv ====
`default_nettype none

`include "rv32_macros.svh"

package rv32_pkg;

    // major opcodes the pipe accepts
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } rv32_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,        // pc + 4
        WB_LOAD
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv32_inst_u;

    typedef struct packed {
        logic                   valid;
        logic [`RV32_XLEN-1:0]  pc;
        logic [`RV32_XLEN-1:0]  rs1_val;
        logic [`RV32_XLEN-1:0]  rs2_val;
        logic [`RV32_XLEN-1:0]  imm;
        logic [`RV32_REG_W-1:0] rd;
        logic [2:0]             funct3;
        alu_op_e                alu_op;
        logic                   op_a_pc;
        logic                   op_b_imm;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_jalr;
        logic                   is_load;
        logic                   is_store;
        logic                   reg_write;
        wb_sel_e                wb_sel;
    } dec_stage_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV32_REG_W-1:0] rd;
        logic                   reg_write;
        logic [`RV32_XLEN-1:0]  alu_res;    // doubles as memory address
        logic [`RV32_XLEN-1:0]  link;
        wb_sel_e                wb_sel;
        logic [2:0]             funct3;
        logic [1:0]             byte_off;   // already aligned to access size
        logic                   redirect;
        logic [`RV32_XLEN-1:0]  redirect_pc;
    } exe_stage_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV32_REG_W-1:0] rd;
        logic [`RV32_XLEN-1:0]  data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rv32_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_regfile import rv32_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`RV32_REG_W-1:0] rs1_idx,
    input  wire logic [`RV32_REG_W-1:0] rs2_idx,
    input  wire wb_t                    wr,
    output logic      [`RV32_XLEN-1:0]  rs1_val,
    output logic      [`RV32_XLEN-1:0]  rs2_val
);

    // x0 has no storage
    logic [`RV32_XLEN-1:0] regs [1:`RV32_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV32_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // no write-through, the new value shows up the cycle after
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // decode clears reg_write for rd == 0 two stages earlier
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr.valid |-> wr.rd != '0);

endmodule

`default_nettype wire

// ==== rv32_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_result import rv32_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire exe_stage_t            exe,
    input  wire logic [`RV32_XLEN-1:0] data_rdata,
    output wb_t                        res_fwd,
    output wb_t                        wb,
    output logic                       redirect_valid,
    output logic      [`RV32_XLEN-1:0] redirect_pc
);

    logic [`RV32_XLEN-1:0] lane;
    logic [`RV32_XLEN-1:0] load_val;
    wb_t                   wb_d;

    // addressed byte or halfword moved down to bit 0
    assign lane = data_rdata >> {exe.byte_off, 3'b000};

    always_comb begin
        case (exe.funct3)
            3'b000:  load_val = {{24{lane[7]}}, lane[7:0]};     // lb
            3'b001:  load_val = {{16{lane[15]}}, lane[15:0]};   // lh
            3'b100:  load_val = {24'b0, lane[7:0]};             // lbu
            3'b101:  load_val = {16'b0, lane[15:0]};            // lhu
            default: load_val = data_rdata;
        endcase
    end

    always_comb begin
        wb_d.valid = exe.reg_write;     // already qualified by valid
        wb_d.rd    = exe.rd;
        case (exe.wb_sel)
            WB_LINK: wb_d.data = exe.link;
            WB_LOAD: wb_d.data = load_val;
            default: wb_d.data = exe.alu_res;
        endcase
    end

    assign res_fwd = wb_d;  // includes load data

    always_ff @(posedge clk) begin
        wb          <= wb_d;
        redirect_pc <= exe.redirect_pc;
        if (!rst_n) begin
            wb.valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= exe.redirect;
        end
    end

    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> wb.rd != '0);

endmodule

`default_nettype wire

// ==== tb_rv32_model.svh ====
`ifndef TB_RV32_MODEL_SVH
`define TB_RV32_MODEL_SVH

// what the ports should show for one issue slot
typedef struct packed {
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        rd_en;
    logic        wr_en;
    logic [31:0] addr;
    logic [3:0]  mbe;
    logic [31:0] wdata;     // lanes already placed by offset
} exp_t;

logic [31:0] lcg_state;
logic [31:0] ref_regs [0:31];
logic [31:0] ref_mem [0:63];

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);   // fold high bits down
endfunction

// small register set keeps dependencies frequent
function automatic logic [31:0] gen_inst();
    logic [31:0] r;
    logic [31:0] k;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    r   = next_rand();
    k   = next_rand();
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    imm = {4'b0, k[27:20]};     // x0 based so it stays inside 64 words
    case (k[3:0])
        4'd0, 4'd1, 4'd2, 4'd3: begin
            if (f3 == 3'b000 || f3 == 3'b101) begin
                return {1'b0, k[4], 5'b0, rs2, rs1, f3, rd, OP_REG};
            end
            return {7'b0, rs2, rs1, f3, rd, OP_REG};
        end
        4'd4, 4'd5, 4'd6: begin
            if (f3 == 3'b001) begin
                return {7'b0, k[24:20], rs1, f3, rd, OP_IMM};
            end
            if (f3 == 3'b101) begin
                return {1'b0, k[4], 5'b0, k[24:20], rs1, f3, rd, OP_IMM};
            end
            return {k[31:20], rs1, f3, rd, OP_IMM};
        end
        4'd7:    return {k[31:12], rd, OP_LUI};
        4'd8:    return {k[31:12], rd, OP_AUIPC};
        4'd9:    return {k[31:12], rd, OP_JAL};
        4'd10:   return {k[31:20], rs1, 3'b000, rd, OP_JALR};
        4'd11: begin
            if (f3[2:1] == 2'b01) begin
                f3 = {2'b00, f3[0]};    // no branch at 010 / 011
            end
            return {k[31:25], rs2, rs1, f3, k[11:7], OP_BRANCH};
        end
        4'd12, 4'd13: begin
            if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                f3 = 3'b010;
            end
            return {imm, 5'd0, f3, rd, OP_LOAD};
        end
        default: begin
            f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
            return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE};
        end
    endcase
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic is_reg,
                                        input logic alt, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
        3'b000:  return (is_reg && alt) ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// architectural step at issue time that updates ref_regs and ref_mem
task automatic run_model(input logic [31:0] iw, input logic [31:0] pc, output exp_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] b_lane;
    logic [31:0] h_lane;
    logic [31:0] res;
    logic [2:0]  f3;
    logic [1:0]  off;
    logic        taken;
    a       = ref_regs[iw[19:15]];
    b       = ref_regs[iw[24:20]];
    f3      = iw[14:12];
    imm_i   = {{20{iw[31]}}, iw[31:20]};
    imm_s   = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    e       = '0;
    e.wb_rd = iw[11:7];
    res     = pc + 32'd4;   // link value
    case (iw[6:0])
        OP_LUI: begin
            res        = {iw[31:12], 12'b0};
            e.wb_valid = 1'b1;
        end
        OP_AUIPC: begin
            res        = pc + {iw[31:12], 12'b0};
            e.wb_valid = 1'b1;
        end
        OP_JAL: begin
            e.wb_valid       = 1'b1;
            e.redirect_valid = 1'b1;
            e.redirect_pc    = pc + {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        end
        OP_JALR: begin
            e.wb_valid       = 1'b1;
            e.redirect_valid = 1'b1;
            e.redirect_pc    = (a + imm_i) & ~32'd1;
        end
        OP_BRANCH: begin
            case (f3)
                3'b000:  taken = a == b;
                3'b001:  taken = a != b;
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                default: taken = a >= b;
            endcase
            e.redirect_valid = taken;
            e.redirect_pc    = pc + {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        end
        OP_LOAD: begin
            addr       = a + imm_i;
            word       = ref_mem[addr[7:2]];
            b_lane     = word >> {addr[1:0], 3'b000};
            h_lane     = word >> {addr[1], 4'b0000};
            e.rd_en    = 1'b1;
            e.addr     = {addr[31:2], 2'b00};
            e.mbe      = (f3[1:0] == 2'b10) ? 4'b1111 :
                         f3[0] ? (4'b0011 << {addr[1], 1'b0}) : (4'b0001 << addr[1:0]);
            e.wb_valid = 1'b1;
            case (f3)
                3'b000:  res = {{24{b_lane[7]}}, b_lane[7:0]};
                3'b001:  res = {{16{h_lane[15]}}, h_lane[15:0]};
                3'b100:  res = {24'b0, b_lane[7:0]};
                3'b101:  res = {16'b0, h_lane[15:0]};
                default: res = word;
            endcase
        end
        OP_STORE: begin
            addr    = a + imm_s;
            off     = (f3 == 3'b010) ? 2'b00 : (f3 == 3'b001) ? {addr[1], 1'b0} : addr[1:0];
            e.mbe   = (f3 == 3'b010) ? 4'b1111 :
                      (f3 == 3'b001) ? (4'b0011 << off) : (4'b0001 << off);
            e.wr_en = 1'b1;
            e.addr  = {addr[31:2], 2'b00};
            e.wdata = b << {off, 3'b000};
            for (int i = 0; i < 4; i++) begin
                if (e.mbe[i]) begin
                    ref_mem[addr[7:2]][8*i +: 8] = e.wdata[8*i +: 8];
                end
            end
        end
        default: begin
            res        = alu_ref(f3, iw[6:0] == OP_REG, iw[30], a,
                                 (iw[6:0] == OP_REG) ? b : imm_i);
            e.wb_valid = 1'b1;
        end
    endcase
    e.wb_valid = e.wb_valid && e.wb_rd != 5'd0;    // x0 never written
    e.wb_data  = res;
    if (e.wb_valid) begin
        ref_regs[e.wb_rd] = res;
    end
endtask

`endif

// ==== tb_rv32_int_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_int_pipe import rv32_pkg::*; ();

    localparam int N_SLOTS        = 400;
    localparam int DRAIN_SLOTS    = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = N_SLOTS + 50;
    localparam logic [31:0] SEED  = 32'h11da_c71a;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic [31:0] data_rdata;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_mbe;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    logic [31:0] dmem [0:63];
    logic        checking = 1'b0;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    `include "tb_rv32_model.svh"

    exp_t exp_q[$];     // four entries with [0] three slots old

    always #4 clk = ~clk;

    rv32_int_pipe u_rv32_int_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .data_rdata     (data_rdata),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_mbe       (data_mbe),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // zero wait state data memory
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_write) begin
            for (int i = 0; i < 4; i++) begin
                if (data_mbe[i]) begin
                    dmem[data_addr[7:2]][8*i +: 8] <= data_wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return (32'h9e37_79b9 * {26'b0, idx} + 32'h0101_0101) ^ {idx, idx, idx, idx, 8'h5a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        exp_t        w;
        exp_t        m;
        logic [31:0] lane_mask;
        if (checking) begin
            w = exp_q[0];
            m = exp_q[1];   // memory request is one cycle earlier than wb
            lane_mask = {{8{m.mbe[3]}}, {8{m.mbe[2]}}, {8{m.mbe[1]}}, {8{m.mbe[0]}}};
            check_value("wb_valid", wb_valid, w.wb_valid);
            if (w.wb_valid) begin
                check_value("wb_rd", wb_rd, w.wb_rd);
                check_value("wb_data", wb_data, w.wb_data);
            end
            check_value("redirect_valid", redirect_valid, w.redirect_valid);
            if (w.redirect_valid) begin
                check_value("redirect_pc", redirect_pc, w.redirect_pc);
            end
            check_value("data_read", data_read, m.rd_en);
            check_value("data_write", data_write, m.wr_en);
            if (m.rd_en || m.wr_en) begin
                check_value("data_addr", data_addr, m.addr);
                check_value("data_mbe", data_mbe, m.mbe);
            end
            if (m.wr_en) begin
                check_value("data_wdata", data_wdata & lane_mask, m.wdata & lane_mask);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        logic [31:0] iw;
        logic [31:0] pc;
        logic        after_load;
        logic        bubble;
        exp_t        e;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        lcg_state  = SEED;
        pc         = 32'h0000_1000;
        after_load = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = fill_word(i[5:0]);
            ref_mem[i] = fill_word(i[5:0]);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        e = '0;
        repeat (3) exp_q.push_back(e);     // pipe is empty out of reset
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int slot = 0; slot < N_SLOTS + DRAIN_SLOTS; slot++) begin
            e      = '0;
            iw     = '0;
            bubble = slot < 4 || slot >= N_SLOTS || after_load ||
                     (next_rand() & 32'h7) == 32'h0;
            if (!bubble) begin
                iw = gen_inst();
                run_model(iw, pc, e);
            end
            after_load = !bubble && iw[6:0] == OP_LOAD;  // keeps the load-use gap
            inst_valid <= !bubble;
            inst       <= iw;
            inst_pc    <= pc;
            pc         = pc + 32'd4;
            exp_q.push_back(e);
            if (exp_q.size() > 4) begin
                void'(exp_q.pop_front());
            end
            checking = 1'b1;
            @(posedge clk);
        end
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
